//--- Bender.yml
package:
  name: branchPredictor

sources:
  - common/bpuPkg.sv
  - common/resolveIfc.sv
  - rtl/branchHistoryTable.sv
  - rtl/returnStack.sv
  - bpu/predictStage.sv
  - bpu/branchPredictor.sv
  - target: test
    files:
      - verif/branchPredictorTb.sv

//--- bpu/branchPredictor.sv
/*
 * Branch predictor top level.
 * Joins the history table, return stack and prediction stage and maps the
 * resolve ports onto the shared resolve bus.
 */
module branchPredictor #(
    parameter int indexBits = 6,
    parameter int rasDepth  = 8
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            fetchWr,
    input  logic            fetchFlush,
    input  bpuPkg::pcT      fetchPc,
    input  logic            resValid,
    input  bpuPkg::pcT      resPc,
    input  bpuPkg::pcT      resTarget,
    input  bpuPkg::brTypeT  resType,
    input  logic            resTaken,
    input  logic            resHit,
    input  bpuPkg::counterT resCount,
    output bpuPkg::pcT      predTarget,
    output logic            predTaken,
    output logic            predHit,
    output bpuPkg::brTypeT  predType,
    output bpuPkg::counterT predCount,
    output logic            predValid
);
    import bpuPkg::*;

    localparam int tagBits = 30 - indexBits;

    resolveIfc resBus ();

    logic [tagBits-1:0] rdTag;
    pcT                 rdTarget;
    brTypeT             rdType;
    counterT            rdCount;
    pcT                 rasAddr;
    logic               rasValid;

    // execute side drives the resolve bus
    assign resBus.valid  = resValid;
    assign resBus.pc     = resPc;
    assign resBus.target = resTarget;
    assign resBus.brType = resType;
    assign resBus.taken  = resTaken;
    assign resBus.hit    = resHit;
    assign resBus.count  = resCount;

    branchHistoryTable #(
        .indexBits (indexBits)
    ) bht0 (
        .clk      (clk),
        .rstN     (rstN),
        .fetchPc  (fetchPc),
        .res      (resBus.sink),
        .rdTag    (rdTag),
        .rdTarget (rdTarget),
        .rdType   (rdType),
        .rdCount  (rdCount)
    );

    returnStack #(
        .rasDepth (rasDepth)
    ) ras0 (
        .clk      (clk),
        .rstN     (rstN),
        .res      (resBus.sink),
        .rasAddr  (rasAddr),
        .rasValid (rasValid)
    );

    predictStage #(
        .indexBits (indexBits)
    ) pred0 (
        .clk        (clk),
        .rstN       (rstN),
        .fetchWr    (fetchWr),
        .fetchFlush (fetchFlush),
        .fetchPc    (fetchPc),
        .rdTag      (rdTag),
        .rdTarget   (rdTarget),
        .rdType     (rdType),
        .rdCount    (rdCount),
        .rasAddr    (rasAddr),
        .rasValid   (rasValid),
        .predTarget (predTarget),
        .predTaken  (predTaken),
        .predHit    (predHit),
        .predType   (predType),
        .predCount  (predCount),
        .predValid  (predValid)
    );

endmodule

//--- bpu/predictStage.sv
/*
 * Prediction stage.
 * Registers the table and stack read when fetch advances, then compares
 * tags and selects the predicted next PC one cycle later.
 */
module predictStage #(
    parameter int indexBits = 6,
    localparam int tagBits = 30 - indexBits
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               fetchWr,
    input  logic               fetchFlush,
    input  bpuPkg::pcT         fetchPc,
    input  logic [tagBits-1:0] rdTag,
    input  bpuPkg::pcT         rdTarget,
    input  bpuPkg::brTypeT     rdType,
    input  bpuPkg::counterT    rdCount,
    input  bpuPkg::pcT         rasAddr,
    input  logic               rasValid,
    output bpuPkg::pcT         predTarget,
    output logic               predTaken,
    output logic               predHit,
    output bpuPkg::brTypeT     predType,
    output bpuPkg::counterT    predCount,
    output logic               predValid
);
    import bpuPkg::*;

    logic [tagBits-1:0] fetchTag;
    pcT                 fetchPcAdd8;

    // prediction register
    logic [tagBits-1:0] regTag;
    logic [tagBits-1:0] regPcTag;
    pcT                 regTarget;
    pcT                 regRasAddr;
    logic               regRasValid;
    pcT                 regPcAdd8;
    brTypeT             regType;
    counterT            regCount;
    logic               regValid;
    // set by a capture, so an empty register never reports a hit
    logic               regFilled;

    logic tagHit;

    assign fetchTag    = fetchPc[31:indexBits+2];
    assign fetchPcAdd8 = fetchPc + pcStep;

    // flush wins over capture, no capture holds the register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regTag      <= '0;
            regPcTag    <= '0;
            regTarget   <= '0;
            regRasAddr  <= '0;
            regRasValid <= 1'b0;
            regPcAdd8   <= '0;
            regType     <= brNone;
            regCount    <= cntStrongNt;
            regValid    <= 1'b0;
            regFilled   <= 1'b0;
        end else if (fetchFlush) begin
            regTag      <= '0;
            regPcTag    <= '0;
            regTarget   <= '0;
            regRasAddr  <= '0;
            regRasValid <= 1'b0;
            regPcAdd8   <= '0;
            regType     <= brNone;
            regCount    <= cntStrongNt;
            regValid    <= 1'b0;
            regFilled   <= 1'b0;
        end else if (fetchWr) begin
            regTag      <= rdTag;
            regPcTag    <= fetchTag;
            regTarget   <= rdTarget;
            regRasAddr  <= rasAddr;
            regRasValid <= rasValid;
            regPcAdd8   <= fetchPcAdd8;
            regType     <= rdType;
            regCount    <= rdCount;
            // the fetch after a taken prediction is on the wrong path
            regValid    <= ~predTaken;
            regFilled   <= 1'b1;
        end
    end

    assign tagHit = regFilled && (regTag == regPcTag);

    // next-PC selection
    always_comb begin
        predTarget = regPcAdd8;
        predTaken  = 1'b0;
        if (tagHit) begin
            case (regType)
                brCall: begin
                    predTarget = regTarget;
                    predTaken  = 1'b1;
                end
                brRetn: begin
                    // empty slot falls back to sequential fetch, still redirected
                    predTarget = regRasValid ? regRasAddr : regPcAdd8;
                    predTaken  = 1'b1;
                end
                brImme: begin
                    if (cntTaken(regCount)) begin
                        predTarget = regTarget;
                        predTaken  = 1'b1;
                    end
                end
                default: begin
                    predTarget = regPcAdd8;
                    predTaken  = 1'b0;
                end
            endcase
        end
    end

    assign predHit   = tagHit;
    assign predType  = tagHit ? regType : brNone;
    assign predCount = regCount;
    assign predValid = regValid;

endmodule

//--- branchPredictor.f
common/bpuPkg.sv
common/resolveIfc.sv
rtl/branchHistoryTable.sv
rtl/returnStack.sv
bpu/predictStage.sv
bpu/branchPredictor.sv
verif/branchPredictorTb.sv

//--- common/bpuPkg.sv
/*
 * Branch predictor shared definitions.
 * Address, branch class and counter types and codes, plus the entry widths
 * used by the history table and the return stack.
 */
package bpuPkg;

    // instruction address
    localparam int pcBits = 32;
    typedef logic [pcBits-1:0] pcT;

    // fall-through distance, branch plus its delay slot
    localparam pcT pcStep = 32'd8;

    // branch class as recorded by execute
    localparam int brTypeBits = 2;
    typedef logic [brTypeBits-1:0] brTypeT;

    localparam brTypeT brNone = 2'd0;
    localparam brTypeT brImme = 2'd1;
    localparam brTypeT brCall = 2'd2;
    localparam brTypeT brRetn = 2'd3;

    // 2-bit saturating counter
    localparam int counterBits = 2;
    typedef logic [counterBits-1:0] counterT;

    localparam counterT cntStrongNt = 2'd0;
    localparam counterT cntWeakNt   = 2'd1;
    localparam counterT cntWeakT    = 2'd2;
    localparam counterT cntStrongT  = 2'd3;

    // table entry payload without the tag, packed as {target, type, count}
    // tag width depends on the index width and is added by the table itself
    localparam int bhtDataBits = pcBits + brTypeBits + counterBits;

    // stack entry packed as {valid, address}
    localparam int rasEntryBits = pcBits + 1;

    // upper counter bit set means predict taken
    function automatic logic cntTaken(input counterT count);
        return count[counterBits-1];
    endfunction

endpackage

//--- common/resolveIfc.sv
/*
 * Resolved branch from execute.
 * Carries one outcome per valid strobe to the history table and the
 * return stack, with no back-pressure.
 */
interface resolveIfc;
    import bpuPkg::*;

    // one-cycle strobe, one resolution per cycle it is high
    logic    valid;
    pcT      pc;
    pcT      target;
    brTypeT  brType;
    logic    taken;
    // table hit and counter as seen at prediction time
    logic    hit;
    counterT count;

    modport source (
        output valid,
        output pc,
        output target,
        output brType,
        output taken,
        output hit,
        output count
    );

    modport sink (
        input valid,
        input pc,
        input target,
        input brType,
        input taken,
        input hit,
        input count
    );

endinterface

//--- rtl/branchHistoryTable.sv
/*
 * Branch history table.
 * Direct-mapped tag, target, type and counter storage. Read is combinational
 * on the fetch PC; a resolved branch rewrites its entry with the new counter.
 */
module branchHistoryTable #(
    parameter int indexBits = 6,
    localparam int tagBits = 30 - indexBits
) (
    input  logic             clk,
    input  logic             rstN,
    input  bpuPkg::pcT       fetchPc,
    resolveIfc.sink          res,
    output logic [tagBits-1:0] rdTag,
    output bpuPkg::pcT       rdTarget,
    output bpuPkg::brTypeT   rdType,
    output bpuPkg::counterT  rdCount
);
    import bpuPkg::*;

    localparam int numEntries = 2 ** indexBits;
    localparam int entryBits  = tagBits + bhtDataBits;

    logic [entryBits-1:0] entries [numEntries];

    logic [indexBits-1:0] rdIdx;
    logic [indexBits-1:0] wrIdx;
    logic [entryBits-1:0] rdEntry;
    logic [entryBits-1:0] wrEntry;
    counterT              wrCount;

    // index is PC bits 2 and up, tag is everything above
    assign rdIdx = fetchPc[indexBits+1:2];
    assign wrIdx = res.pc[indexBits+1:2];

    // counter update
    always_comb begin
        if (!res.hit) begin
            // fresh entry starts weak in the resolved direction
            wrCount = res.taken ? cntWeakT : cntWeakNt;
        end else if (res.taken) begin
            wrCount = (res.count == cntStrongT) ? cntStrongT : counterT'(res.count + 1'b1);
        end else begin
            wrCount = (res.count == cntStrongNt) ? cntStrongNt : counterT'(res.count - 1'b1);
        end
    end

    assign wrEntry = {res.pc[31:indexBits+2], res.target, res.brType, wrCount};

    // write lands at the edge after the strobe, same-cycle reads see old data
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numEntries; i++) begin
                entries[i] <= '0;
            end
        end else if (res.valid) begin
            entries[wrIdx] <= wrEntry;
        end
    end

    assign rdEntry = entries[rdIdx];

    assign rdTag    = rdEntry[entryBits-1 -: tagBits];
    assign rdTarget = rdEntry[bhtDataBits-1 -: pcBits];
    assign rdType   = rdEntry[brTypeBits+counterBits-1 -: brTypeBits];
    assign rdCount  = rdEntry[counterBits-1:0];

endmodule

//--- rtl/returnStack.sv
/*
 * Return address stack.
 * Circular stack pushed by resolved calls and popped by resolved returns,
 * with a resolving call bypassed straight onto the outputs.
 */
module returnStack #(
    parameter int rasDepth = 8
) (
    input  logic       clk,
    input  logic       rstN,
    resolveIfc.sink    res,
    output bpuPkg::pcT rasAddr,
    output logic       rasValid
);
    import bpuPkg::*;

    localparam int ptrBits = $clog2(rasDepth);

    logic [rasEntryBits-1:0] stack [rasDepth];

    // top points at the next free slot
    logic [ptrBits-1:0] topPtr;
    logic [ptrBits-1:0] belowTop;
    logic               callWr;
    logic               retnWr;
    pcT                 callAddr;

    assign belowTop = topPtr - 1'b1;
    assign callWr   = res.valid && (res.brType == brCall);
    assign retnWr   = res.valid && (res.brType == brRetn);
    assign callAddr = res.pc + pcStep;

    // pointer wraps, a pop leaves the entry valid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            topPtr <= '0;
            for (int i = 0; i < rasDepth; i++) begin
                stack[i] <= '0;
            end
        end else if (callWr) begin
            stack[topPtr] <= {1'b1, callAddr};
            topPtr        <= topPtr + 1'b1;
        end else if (retnWr) begin
            topPtr <= belowTop;
        end
    end

    // same-cycle push bypass
    always_comb begin
        if (callWr) begin
            rasValid = 1'b1;
            rasAddr  = callAddr;
        end else begin
            {rasValid, rasAddr} = stack[belowTop];
        end
    end

endmodule

//--- verif/branchPredictorTb.sv
/*
 * Branch predictor testbench.
 * Directed tests for the history table, return stack and prediction stage,
 * checked against a small table-and-stack model of the prediction rules.
 */
module branchPredictorTb;
    import bpuPkg::*;

    localparam int indexBits   = 6;
    localparam int rasDepth    = 8;
    localparam int tagBits     = 30 - indexBits;
    localparam int numEntries  = 2 ** indexBits;
    localparam int edgeTimeout = 10;

    typedef logic [tagBits-1:0] tagT;

    logic clk;
    logic rstN;
    logic fetchWr;
    logic fetchFlush;
    pcT fetchPc;
    logic resValid;
    pcT resPc;
    pcT resTarget;
    brTypeT resType;
    logic resTaken;
    logic resHit;
    counterT resCount;
    pcT predTarget;
    logic predTaken;
    logic predHit;
    brTypeT predType;
    counterT predCount;
    logic predValid;

    // table and stack model
    tagT mTag [numEntries];
    pcT mTarget [numEntries];
    brTypeT mType [numEntries];
    counterT mCount [numEntries];
    pcT mRasAddr [rasDepth];
    logic mRasValid [rasDepth];
    int mTop;

    // model of the prediction register
    tagT rTag;
    tagT rPcTag;
    pcT rTarget;
    pcT rRasAddr;
    logic rRasValid;
    pcT rPcAdd8;
    brTypeT rType;
    counterT rCount;
    logic rValid;
    logic rFilled;

    int posEdges = 0;
    int nChecks = 0;
    int nErrors = 0;
    logic [31:0] lcgState = 32'd43313;

    branchPredictor #(
        .indexBits (indexBits),
        .rasDepth  (rasDepth)
    ) dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .fetchWr    (fetchWr),
        .fetchFlush (fetchFlush),
        .fetchPc    (fetchPc),
        .resValid   (resValid),
        .resPc      (resPc),
        .resTarget  (resTarget),
        .resType    (resType),
        .resTaken   (resTaken),
        .resHit     (resHit),
        .resCount   (resCount),
        .predTarget (predTarget),
        .predTaken  (predTaken),
        .predHit    (predHit),
        .predType   (predType),
        .predCount  (predCount),
        .predValid  (predValid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) posEdges <= posEdges + 1;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int indexOf(input pcT pc);
        return int'((pc >> 2) % numEntries);
    endfunction

    function automatic tagT tagOf(input pcT pc);
        return tagT'(pc >> (indexBits + 2));
    endfunction

    task automatic report();
        $display("checks run: %0d, errors: %0d", nChecks, nErrors);
        if (nErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic checkPc(input pcT got, input pcT exp, input string what);
        nChecks++;
        if (got !== exp) begin
            nErrors++;
            $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkType(input brTypeT got, input brTypeT exp, input string what);
        nChecks++;
        if (got !== exp) begin
            nErrors++;
            $display("CHECK FAILED t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input counterT got, input counterT exp, input string what);
        nChecks++;
        if (got !== exp) begin
            nErrors++;
            $display("CHECK FAILED t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        nChecks++;
        if (got !== exp) begin
            nErrors++;
            $display("CHECK FAILED t=%0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // waits for one rising edge and returns on the falling edge after it
    task automatic waitCycle();
        int start;
        int waited;
        start = posEdges;
        waited = 0;
        while (posEdges == start && waited < edgeTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (posEdges == start) begin
            nErrors++;
            $display("clock stopped: no rising edge within %0d cycles", edgeTimeout);
            report();
        end
    endtask

    function automatic logic modelHit();
        return rFilled && (rTag == rPcTag);
    endfunction

    task automatic modelSelect(output pcT tgt, output logic taken);
        tgt = rPcAdd8;
        taken = 1'b0;
        if (modelHit()) begin
            if (rType == brCall) begin
                tgt = rTarget;
                taken = 1'b1;
            end else if (rType == brRetn) begin
                taken = 1'b1;
                if (rRasValid) tgt = rRasAddr;
            end else if (rType == brImme && rCount >= cntWeakT) begin
                tgt = rTarget;
                taken = 1'b1;
            end
        end
    endtask

    task automatic modelReset();
        for (int i = 0; i < numEntries; i++) begin
            mTag[i] = '0;
            mTarget[i] = '0;
            mType[i] = brNone;
            mCount[i] = cntStrongNt;
        end
        for (int i = 0; i < rasDepth; i++) begin
            mRasAddr[i] = '0;
            mRasValid[i] = 1'b0;
        end
        mTop = 0;
        {rTag, rPcTag, rTarget, rRasAddr, rRasValid, rPcAdd8} = '0;
        {rType, rCount, rValid, rFilled} = '0;
    endtask

    // applies the current inputs to the model as the next edge will
    task automatic modelStep();
        pcT curTgt;
        logic curTaken;
        int idx;
        int below;
        int cnt;
        modelSelect(curTgt, curTaken);
        if (fetchFlush) begin
            {rTag, rPcTag, rTarget, rRasAddr, rRasValid, rPcAdd8} = '0;
            {rType, rCount, rValid, rFilled} = '0;
        end else if (fetchWr) begin
            idx = indexOf(fetchPc);
            rTag = mTag[idx];
            rPcTag = tagOf(fetchPc);
            rTarget = mTarget[idx];
            rType = mType[idx];
            rCount = mCount[idx];
            if (resValid && resType == brCall) begin
                rRasAddr = resPc + pcStep;
                rRasValid = 1'b1;
            end else begin
                below = (mTop + rasDepth - 1) % rasDepth;
                rRasAddr = mRasAddr[below];
                rRasValid = mRasValid[below];
            end
            rPcAdd8 = fetchPc + pcStep;
            rValid = !curTaken;
            rFilled = 1'b1;
        end
        if (resValid) begin
            idx = indexOf(resPc);
            if (!resHit) cnt = resTaken ? 2 : 1;
            else if (resTaken) cnt = (resCount < 3) ? resCount + 1 : 3;
            else cnt = (resCount > 0) ? resCount - 1 : 0;
            mTag[idx] = tagOf(resPc);
            mTarget[idx] = resTarget;
            mType[idx] = resType;
            mCount[idx] = counterT'(cnt);
            if (resType == brCall) begin
                mRasAddr[mTop] = resPc + pcStep;
                mRasValid[mTop] = 1'b1;
                mTop = (mTop + 1) % rasDepth;
            end else if (resType == brRetn) begin
                mTop = (mTop + rasDepth - 1) % rasDepth;
            end
        end
    endtask

    task automatic driveResolve(input pcT pc, input pcT tgt, input brTypeT kind,
                                input logic taken, input logic hit, input counterT count);
        resValid = 1'b1;
        resPc = pc;
        resTarget = tgt;
        resType = kind;
        resTaken = taken;
        resHit = hit;
        resCount = count;
    endtask

    task automatic driveFetch(input logic wr, input logic flush, input pcT pc);
        fetchWr = wr;
        fetchFlush = flush;
        fetchPc = pc;
    endtask

    // strobes are dropped again on the falling edge
    task automatic tick();
        modelStep();
        waitCycle();
        resValid = 1'b0;
        fetchWr = 1'b0;
        fetchFlush = 1'b0;
    endtask

    task automatic checkOutputs(input string what);
        pcT expTgt;
        logic expTaken;
        logic expHit;
        expHit = modelHit();
        modelSelect(expTgt, expTaken);
        checkPc(predTarget, expTgt, {what, " predTarget"});
        checkBit(predTaken, expTaken, {what, " predTaken"});
        checkBit(predHit, expHit, {what, " predHit"});
        checkType(predType, expHit ? rType : brNone, {what, " predType"});
        checkCount(predCount, rCount, {what, " predCount"});
        checkBit(predValid, rValid, {what, " predValid"});
    endtask

    task automatic capture(input pcT pc, input string what);
        driveFetch(1'b1, 1'b0, pc);
        tick();
        checkOutputs(what);
    endtask

    task automatic resetAndColdMiss();
        pcT pc;
        pc = 32'h0040_1000;
        checkBit(predValid, 1'b0, "reset predValid");
        checkBit(predTaken, 1'b0, "reset predTaken");
        checkBit(predHit, 1'b0, "reset predHit");
        checkPc(predTarget, '0, "reset predTarget");
        capture(pc, "cold miss");
        checkBit(predHit, 1'b0, "cold miss hit");
        checkType(predType, brNone, "cold miss type");
        checkPc(predTarget, pc + 32'd8, "cold miss target");
        checkBit(predValid, 1'b1, "cold miss valid");
    endtask

    task automatic counterTraining();
        pcT pc;
        pcT tgt;
        pc = 32'h0040_0010;
        tgt = 32'h0040_0400;
        driveResolve(pc, tgt, brImme, 1'b1, 1'b0, cntStrongNt);
        tick();
        capture(pc, "trained taken");
        checkCount(predCount, cntWeakT, "first count");
        checkBit(predTaken, 1'b1, "first taken");
        checkPc(predTarget, tgt, "first target");
        for (int k = 0; k < 3; k++) begin
            driveResolve(pc, tgt, brImme, 1'b0, 1'b1, rCount);
            tick();
            capture(pc, "not-taken training");
        end
        checkCount(predCount, cntStrongNt, "saturated count");
        checkBit(predTaken, 1'b0, "saturated taken");
        checkPc(predTarget, pc + 32'd8, "saturated target");
    endtask

    task automatic callsAndReturns();
        pcT retPc;
        pcT callA;
        pcT callB;
        pcT callC;
        retPc = 32'h0040_0800;
        // calls use their own table indices so the return entry stays in place
        callA = 32'h0040_0104;
        callB = 32'h0040_0208;
        callC = 32'h0040_030c;
        driveResolve(retPc, 32'h0040_0900, brRetn, 1'b1, 1'b0, cntStrongNt);
        tick();
        // slot below the top was never pushed
        capture(retPc, "empty stack return");
        checkPc(predTarget, retPc + 32'd8, "empty return target");
        checkBit(predTaken, 1'b1, "empty return taken");
        driveResolve(callA, retPc, brCall, 1'b1, 1'b0, cntStrongNt);
        capture(retPc, "bypassed return");
        checkPc(predTarget, callA + 32'd8, "bypass target");
        driveResolve(callB, retPc, brCall, 1'b1, 1'b0, cntStrongNt);
        tick();
        driveResolve(callC, retPc, brCall, 1'b1, 1'b0, cntStrongNt);
        tick();
        capture(retPc, "nested return 1");
        checkPc(predTarget, callC + 32'd8, "lifo target 1");
        driveResolve(retPc, 32'h0, brRetn, 1'b1, 1'b1, cntWeakT);
        tick();
        capture(retPc, "nested return 2");
        checkPc(predTarget, callB + 32'd8, "lifo target 2");
        driveResolve(retPc, 32'h0, brRetn, 1'b1, 1'b1, cntWeakT);
        tick();
        capture(retPc, "nested return 3");
        checkPc(predTarget, callA + 32'd8, "lifo target 3");
    endtask

    task automatic tagAliasing();
        pcT first;
        pcT second;
        first = 32'h0040_0040;
        second = 32'h0050_0040;
        driveResolve(first, 32'h0040_0a00, brImme, 1'b1, 1'b0, cntStrongNt);
        tick();
        capture(second, "alias miss");
        checkBit(predHit, 1'b0, "alias hit");
        checkPc(predTarget, second + 32'd8, "alias target");
        capture(first, "alias owner");
        checkBit(predHit, 1'b1, "owner hit");
    endtask

    task automatic flushStallValid();
        pcT pc;
        pc = 32'h0040_0040;
        capture(pc, "taken before stall");
        driveFetch(1'b0, 1'b0, 32'h0050_0000);
        tick();
        checkOutputs("stall");
        checkPc(predTarget, 32'h0040_0a00, "stall target");
        checkBit(predTaken, 1'b1, "stall taken");
        capture(pc, "capture after taken");
        checkBit(predValid, 1'b0, "wrong-path valid");
        // not-taken miss, so a capture instead of the flush would set valid
        capture(32'h0050_0000, "miss before flush");
        checkBit(predTaken, 1'b0, "miss before flush taken");
        driveFetch(1'b1, 1'b1, pc);
        tick();
        checkOutputs("flush");
        checkBit(predValid, 1'b0, "flush valid");
        checkBit(predHit, 1'b0, "flush hit");
    endtask

    task automatic randomSweep();
        logic [31:0] r;
        for (int n = 0; n < 200; n++) begin
            r = nextRand();
            resValid = r[31];
            resPc = 32'h0040_0000 + pcT'((int'(r[30:20]) % 96) << 2);
            resType = r[19:18];
            resTaken = r[17];
            resHit = r[16];
            resCount = r[15:14];
            r = nextRand();
            resTarget = {r[31:2], 2'b00};
            r = nextRand();
            fetchWr = r[31];
            fetchFlush = (r[30:27] == 4'd0);
            fetchPc = 32'h0040_0000 + pcT'((int'(r[26:16]) % 96) << 2);
            tick();
            checkOutputs("random");
        end
    endtask

    initial begin
        rstN = 1'b0;
        fetchWr = 1'b0;
        fetchFlush = 1'b0;
        fetchPc = '0;
        resValid = 1'b0;
        resPc = '0;
        resTarget = '0;
        resType = brNone;
        resTaken = 1'b0;
        resHit = 1'b0;
        resCount = cntStrongNt;
        modelReset();
        for (int i = 0; i < 4; i++) begin
            waitCycle();
        end
        rstN = 1'b1;
        resetAndColdMiss();
        counterTraining();
        callsAndReturns();
        tagAliasing();
        flushStallValid();
        randomSweep();
        report();
    end

endmodule
